// ==== verilog/fetch_pkg.sv ====
// shared types and constants of the instruction fetch front end
// all fetches are aligned 32-bit words, no compressed instructions
// boot_addr_i must sit on a 256-byte page, the vectors live in that page
`default_nettype none

package fetch_pkg;

  ////////////////////////////////////////
  // widths with a meaning
  ////////////////////////////////////////

  // byte address of one instruction word
  typedef logic [31:0] fetch_addr_t;
  // one instruction word
  typedef logic [31:0] instr_t;
  // vectored interrupt number
  typedef logic [4:0] irq_id_t;

  // redirect source
  typedef enum logic [2:0] {
    PC_BOOT,
    PC_JUMP,
    PC_EXCEPTION,
    PC_ERET,
    PC_DRET
  } pc_sel_e;

  // exception vector select, used with PC_EXCEPTION
  typedef enum logic [2:0] {
    EXC_ILLINSN,
    EXC_ECALL,
    EXC_BREAKPOINT,
    EXC_IRQ,
    EXC_DBD,
    EXC_DBGEXC
  } exc_sel_e;

  ////////////////////////////////////////
  // vector offsets inside the boot page
  ////////////////////////////////////////
  localparam logic [7:0] OFF_RST        = 8'h80;
  localparam logic [7:0] OFF_ILLINSN    = 8'h84;
  localparam logic [7:0] OFF_ECALL      = 8'h88;
  localparam logic [7:0] OFF_BREAKPOINT = 8'h8c;

  // debug module entry points
  localparam fetch_addr_t DM_HALT_ADDR = 32'h1a110800;
  localparam fetch_addr_t DM_EXC_ADDR  = 32'h1a110808;

  // prefetch queue depth, default of the buffer parameter
  localparam int unsigned PF_DEPTH = 2;

endpackage

`default_nettype wire

// ==== verilog/fetch_addr_sel.sv ====
// next fetch address select, combinational apart from the boot flop
// the boot fetch fires once, on the first cycle with req_i high
// boot_addr_i must be 256-byte aligned
`timescale 1ns/1ps
`default_nettype none

module fetch_addr_sel import fetch_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        req_i,
  input  logic        pc_set_i,
  input  fetch_addr_t boot_addr_i,
  input  pc_sel_e     pc_sel_i,
  input  exc_sel_e    exc_sel_i,
  input  irq_id_t     irq_id_i,
  input  fetch_addr_t jump_target_i,
  input  fetch_addr_t epc_i,
  input  fetch_addr_t depc_i,
  output logic        branch_o,
  output fetch_addr_t branch_addr_o
);

  logic        init_q;
  logic        boot_fetch;
  fetch_addr_t exc_addr;
  fetch_addr_t target;

  // exception vector, offsets live in the boot page
  always_comb begin
    exc_addr = '0;
    unique case (exc_sel_i)
      EXC_ILLINSN:    exc_addr = {boot_addr_i[31:8], OFF_ILLINSN};
      EXC_ECALL:      exc_addr = {boot_addr_i[31:8], OFF_ECALL};
      EXC_BREAKPOINT: exc_addr = {boot_addr_i[31:8], OFF_BREAKPOINT};
      // irq number times 4
      EXC_IRQ:        exc_addr = {boot_addr_i[31:8], 1'b0, irq_id_i, 2'b00};
      EXC_DBD:        exc_addr = DM_HALT_ADDR;
      EXC_DBGEXC:     exc_addr = DM_EXC_ADDR;
      default:        exc_addr = '0;
    endcase
  end

  // redirect target, a pc_set_i wins over the boot fetch
  always_comb begin
    target = {boot_addr_i[31:8], OFF_RST};
    if (pc_set_i) begin
      unique case (pc_sel_i)
        PC_BOOT:      target = {boot_addr_i[31:8], OFF_RST};
        PC_JUMP:      target = jump_target_i;
        PC_EXCEPTION: target = exc_addr;
        PC_ERET:      target = epc_i;
        PC_DRET:      target = depc_i;
        default:      target = {boot_addr_i[31:8], OFF_RST};
      endcase
    end
  end

  // set by reset, cleared by the first request or redirect
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      init_q <= 1'b1;
    end else if (req_i || pc_set_i) begin
      init_q <= 1'b0;
    end
  end

  assign boot_fetch    = init_q & req_i;
  assign branch_o      = boot_fetch | pc_set_i;
  // word fetches only
  assign branch_addr_o = {target[31:2], 2'b00};

  // vectors are built from the upper 24 bits of the boot page
  a_boot_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    req_i |-> (boot_addr_i[7:0] == 8'h00))
    else $error("boot address not aligned to 256 bytes");

endmodule

`default_nettype wire

// ==== verilog/prefetch_buffer.sv ====
// memory bus master and word queue, one request on the bus at a time
// a request waiting for grant keeps its address even across a branch
// granted requests plus queued words never exceed DEPTH (2 or more)
`timescale 1ns/1ps
`default_nettype none

module prefetch_buffer import fetch_pkg::*; #(
  parameter int unsigned DEPTH = PF_DEPTH
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        req_i,
  input  logic        branch_i,
  input  fetch_addr_t branch_addr_i,
  input  logic        fetch_ready_i,
  output logic        fetch_valid_o,
  output instr_t      fetch_rdata_o,
  output fetch_addr_t fetch_addr_o,
  output logic        instr_req_o,
  output fetch_addr_t instr_addr_o,
  input  logic        instr_gnt_i,
  input  logic        instr_rvalid_i,
  input  instr_t      instr_rdata_i
);

  localparam int unsigned PTR_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  // bus side state
  logic              pend_q;
  logic              pend_stale_q;
  fetch_addr_t       req_addr_q;
  fetch_addr_t       next_addr_q;
  fetch_addr_t       resp_addr_q;
  fetch_addr_t       cur_addr;
  logic [CNT_W-1:0]  out_cnt_q;
  logic [CNT_W-1:0]  stale_cnt_q;
  logic [CNT_W-1:0]  stale_now;
  logic [CNT_W:0]    used;
  logic              space_ok;
  logic              gnt;
  logic              req_stale;
  logic              drop;
  logic              keep_word;

  // queue state
  instr_t            fifo_rdata_q [DEPTH];
  fetch_addr_t       fifo_addr_q  [DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [CNT_W-1:0]  fifo_cnt_q;
  logic              fifo_empty;
  logic              push;
  logic              pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  ////////////////////////////////////////
  // request side
  ////////////////////////////////////////
  // a branch restarts from its target in the same cycle
  assign cur_addr = branch_i ? branch_addr_i : next_addr_q;
  // queued words do not count once they are flushed
  assign used     = {1'b0, out_cnt_q} + (branch_i ? '0 : {1'b0, fifo_cnt_q});
  assign space_ok = used < (CNT_W + 1)'(DEPTH);

  assign instr_req_o  = pend_q | (req_i & space_ok);
  assign instr_addr_o = pend_q ? req_addr_q : cur_addr;
  assign gnt          = instr_req_o & instr_gnt_i;
  // held request from before a branch
  assign req_stale    = pend_q & (pend_stale_q | branch_i);

  ////////////////////////////////////////
  // response side
  ////////////////////////////////////////
  // oldest responses owed are the stale ones, they arrive in order
  assign stale_now  = branch_i ? out_cnt_q : stale_cnt_q;
  assign drop       = instr_rvalid_i & (stale_now != '0);
  assign keep_word  = instr_rvalid_i & ~drop;

  assign fifo_empty = (fifo_cnt_q == '0);
  // empty queue passes the word straight through
  assign push = keep_word & ~(fifo_empty & fetch_ready_i);
  assign pop  = fetch_ready_i & ~fifo_empty;

  assign fetch_valid_o = ~branch_i & (~fifo_empty | keep_word);
  assign fetch_rdata_o = fifo_empty ? instr_rdata_i : fifo_rdata_q[rd_ptr_q];
  assign fetch_addr_o  = fifo_empty ? resp_addr_q : fifo_addr_q[rd_ptr_q];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pend_q       <= 1'b0;
      pend_stale_q <= 1'b0;
      next_addr_q  <= '0;
      resp_addr_q  <= '0;
      out_cnt_q    <= '0;
      stale_cnt_q  <= '0;
      wr_ptr_q     <= '0;
      rd_ptr_q     <= '0;
      fifo_cnt_q   <= '0;
    end else begin
      pend_q       <= instr_req_o & ~instr_gnt_i;
      pend_stale_q <= instr_req_o & ~instr_gnt_i & req_stale;
      // a stale grant leaves the branch target in place
      next_addr_q  <= (gnt && !req_stale) ? instr_addr_o + 32'd4 : cur_addr;
      out_cnt_q    <= out_cnt_q + CNT_W'(gnt) - CNT_W'(instr_rvalid_i);
      stale_cnt_q  <= stale_now - CNT_W'(drop) + CNT_W'(gnt & req_stale);
      if (branch_i) begin
        resp_addr_q <= branch_addr_i;
      end else if (keep_word) begin
        resp_addr_q <= resp_addr_q + 32'd4;
      end
      // flush empties the queue
      if (branch_i) begin
        wr_ptr_q   <= '0;
        rd_ptr_q   <= '0;
        fifo_cnt_q <= '0;
      end else begin
        if (push) begin
          wr_ptr_q <= ptr_inc(wr_ptr_q);
        end
        if (pop) begin
          rd_ptr_q <= ptr_inc(rd_ptr_q);
        end
        fifo_cnt_q <= fifo_cnt_q + CNT_W'(push) - CNT_W'(pop);
      end
    end
  end

  // payload, only read while valid
  always_ff @(posedge clk) begin
    req_addr_q <= instr_addr_o;
    if (push) begin
      fifo_rdata_q[wr_ptr_q] <= instr_rdata_i;
      fifo_addr_q[wr_ptr_q]  <= resp_addr_q;
    end
  end

  a_gnt_req: assert property (@(posedge clk) disable iff (!rst_n)
    instr_gnt_i |-> instr_req_o)
    else $error("grant without request");

  a_rvalid_owed: assert property (@(posedge clk) disable iff (!rst_n)
    instr_rvalid_i |-> (out_cnt_q != '0))
    else $error("rvalid with no request outstanding");

  a_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (instr_req_o && !instr_gnt_i) |=> (instr_req_o && $stable(instr_addr_o)))
    else $error("request dropped or address changed before grant");

endmodule

`default_nettype wire

// ==== verilog/if_id_reg.sv ====
// IF/ID register, one instruction with its pc toward decode
// flush_i clears the held word and blocks a load in the same cycle
// halt_i stops loading, the held word can still be taken
`timescale 1ns/1ps
`default_nettype none

module if_id_reg import fetch_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        fetch_valid_i,
  input  instr_t      fetch_rdata_i,
  input  fetch_addr_t fetch_addr_i,
  input  logic        halt_i,
  input  logic        flush_i,
  input  logic        instr_ready_i,
  output logic        fetch_ready_o,
  output logic        instr_valid_o,
  output instr_t      instr_o,
  output fetch_addr_t pc_o
);

  // load when empty or when decode takes the current word
  assign fetch_ready_o = fetch_valid_i & ~halt_i & ~flush_i &
                         (~instr_valid_o | instr_ready_i);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      instr_valid_o <= 1'b0;
    end else if (flush_i) begin
      instr_valid_o <= 1'b0;
    end else if (fetch_ready_o) begin
      instr_valid_o <= 1'b1;
    end else if (instr_ready_i) begin
      // consumed with nothing behind it
      instr_valid_o <= 1'b0;
    end
  end

  // word and pc move only on a load
  always_ff @(posedge clk) begin
    if (fetch_ready_o) begin
      instr_o <= fetch_rdata_i;
      pc_o    <= fetch_addr_i;
    end
  end

  // decode sees a steady word while it stalls
  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (instr_valid_o && !instr_ready_i && !flush_i) |=>
      (instr_valid_o && $stable(instr_o) && $stable(pc_o)))
    else $error("IF/ID word changed under back-pressure");

endmodule

`default_nettype wire

// ==== verilog/fetch_top.sv ====
// fetch front end, address select then prefetch queue then IF/ID register
// memory side is request/grant/rvalid, decode side is valid/ready
`timescale 1ns/1ps
`default_nettype none

module fetch_top import fetch_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  // control from the core
  input  fetch_addr_t boot_addr_i,
  input  logic        req_i,
  input  logic        pc_set_i,
  input  pc_sel_e     pc_sel_i,
  input  exc_sel_e    exc_sel_i,
  input  irq_id_t     irq_id_i,
  input  fetch_addr_t jump_target_i,
  input  fetch_addr_t epc_i,
  input  fetch_addr_t depc_i,
  input  logic        halt_i,
  // instruction memory
  output logic        instr_req_o,
  output fetch_addr_t instr_addr_o,
  input  logic        instr_gnt_i,
  input  logic        instr_rvalid_i,
  input  instr_t      instr_rdata_i,
  // decode port
  output logic        instr_valid_o,
  output instr_t      instr_o,
  output fetch_addr_t pc_o,
  input  logic        instr_ready_i
);

  logic        branch;
  fetch_addr_t branch_addr;
  logic        fetch_valid;
  logic        fetch_ready;
  instr_t      fetch_rdata;
  fetch_addr_t fetch_addr;

  fetch_addr_sel u_addr_sel (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (req_i),
    .pc_set_i      (pc_set_i),
    .boot_addr_i   (boot_addr_i),
    .pc_sel_i      (pc_sel_i),
    .exc_sel_i     (exc_sel_i),
    .irq_id_i      (irq_id_i),
    .jump_target_i (jump_target_i),
    .epc_i         (epc_i),
    .depc_i        (depc_i),
    .branch_o      (branch),
    .branch_addr_o (branch_addr)
  );

  prefetch_buffer #(.DEPTH(PF_DEPTH)) u_prefetch (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req_i),
    .branch_i       (branch),
    .branch_addr_i  (branch_addr),
    .fetch_ready_i  (fetch_ready),
    .fetch_valid_o  (fetch_valid),
    .fetch_rdata_o  (fetch_rdata),
    .fetch_addr_o   (fetch_addr),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i)
  );

  // the same redirect pulse flushes the output register
  if_id_reg u_if_id (
    .clk           (clk),
    .rst_n         (rst_n),
    .fetch_valid_i (fetch_valid),
    .fetch_rdata_i (fetch_rdata),
    .fetch_addr_i  (fetch_addr),
    .halt_i        (halt_i),
    .flush_i       (branch),
    .instr_ready_i (instr_ready_i),
    .fetch_ready_o (fetch_ready),
    .instr_valid_o (instr_valid_o),
    .instr_o       (instr_o),
    .pc_o          (pc_o)
  );

endmodule

`default_nettype wire

// ==== verification/tb_instr_mem.sv ====
// instruction memory model, the word at address a reads as ~a
// grant waits 0 to 3 cycles, rvalid comes 1 to 3 cycles after grant
// responses return in order, at most one per cycle, outputs move on the falling edge
`timescale 1ns/1ps
`default_nettype none

module tb_instr_mem import fetch_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        req_i,
  input  fetch_addr_t addr_i,
  output logic        gnt_o,
  output logic        rvalid_o = 1'b0,
  output instr_t      rdata_o = '0
);

  logic [1:0]  wait_q = 2'd0;
  logic        gnt_ok = 1'b0;
  logic        hs_gnt;
  logic        hs_wait;
  int unsigned cyc;
  // responses owed, with the cycle each one may come back
  instr_t      resp_q [$];
  int unsigned due_q [$];

  // grant only ever answers a live request
  assign gnt_o = req_i & gnt_ok;

  // bus events of the cycle that ends at this edge
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hs_gnt  <= 1'b0;
      hs_wait <= 1'b0;
      cyc     <= 0;
      resp_q.delete();
      due_q.delete();
    end else begin
      hs_gnt  <= req_i & gnt_o;
      hs_wait <= req_i & ~gnt_o;
      cyc     <= cyc + 1;
      if (req_i && gnt_o) begin
        resp_q.push_back(~addr_i);
        due_q.push_back(cyc + 1 + $urandom_range(0, 2));
      end
    end
  end

  ////////////////////////////////////////
  // grant delay and response side
  ////////////////////////////////////////
  always @(negedge clk) begin
    logic [1:0] next_wait;
    next_wait = wait_q;
    if (!rst_n) begin
      wait_q   <= 2'd0;
      gnt_ok   <= 1'b0;
      rvalid_o <= 1'b0;
    end else begin
      // new delay after each grant, count down while a request waits
      if (hs_gnt) begin
        next_wait = 2'($urandom_range(0, 3));
      end else if (hs_wait && next_wait != 2'd0) begin
        next_wait = next_wait - 2'd1;
      end
      wait_q <= next_wait;
      gnt_ok <= (next_wait == 2'd0);
      if (due_q.size() > 0 && due_q[0] <= cyc) begin
        rvalid_o <= 1'b1;
        rdata_o  <= resp_q.pop_front();
        void'(due_q.pop_front());
      end else begin
        rvalid_o <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verification/tb_fetch_top.sv ====
// testbench of the fetch front end with a random-delay memory model
// the boot address sits on a 256-byte page and the memory returns ~address
// inputs move on the falling edge and the run stops at the first error
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_top import fetch_pkg::*;;

  localparam int PHASES           = 14;
  localparam int CYCLES_PER_PHASE = 200;

  logic        clk;
  logic        rst_n;
  fetch_addr_t boot_addr, jump_target, epc, depc;
  logic        req, pc_set, halt;
  pc_sel_e     pc_sel;
  exc_sel_e    exc_sel;
  irq_id_t     irq_id;
  logic        instr_req, instr_gnt, instr_rvalid, instr_valid;
  logic        instr_ready = 1'b1;
  logic        stall_mode  = 1'b0;
  fetch_addr_t instr_addr, pc, exp_pc, hold_pc, bus_addr_q;
  instr_t      instr_rdata, instr, hold_instr;
  logic        req_seen, first_q, hold_q, valid_hold_q, bus_wait_q, accept;
  int          accept_cnt, out_cnt;
  string       phase_name;

  fetch_top u_fetch_top (
    .clk (clk), .rst_n (rst_n), .boot_addr_i (boot_addr), .req_i (req),
    .pc_set_i (pc_set), .pc_sel_i (pc_sel), .exc_sel_i (exc_sel), .irq_id_i (irq_id),
    .jump_target_i (jump_target), .epc_i (epc), .depc_i (depc), .halt_i (halt),
    .instr_req_o (instr_req), .instr_addr_o (instr_addr), .instr_gnt_i (instr_gnt),
    .instr_rvalid_i (instr_rvalid), .instr_rdata_i (instr_rdata),
    .instr_valid_o (instr_valid), .instr_o (instr), .pc_o (pc), .instr_ready_i (instr_ready)
  );

  tb_instr_mem u_instr_mem (
    .clk (clk), .rst_n (rst_n), .req_i (instr_req), .addr_i (instr_addr),
    .gnt_o (instr_gnt), .rvalid_o (instr_rvalid), .rdata_o (instr_rdata)
  );

  task automatic report_value(input string test, input logic [31:0] exp_val,
                              input logic [31:0] act_val);
    $display("error: %s expected %h actual %h", test, exp_val, act_val);
    $display("Done: errors found");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic report_msg(input string what);
    $display("error: %s", what);
    $display("Done: errors found");
    $fatal(1, "run stopped at the first error");
  endtask

  // first fetch address after a redirect, or the boot entry
  function automatic fetch_addr_t redirect_target();
    fetch_addr_t page;
    fetch_addr_t t;
    page = {boot_addr[31:8], 8'h00};
    t    = page + 32'(OFF_RST);
    if (pc_set && pc_sel == PC_JUMP) t = jump_target;
    if (pc_set && pc_sel == PC_ERET) t = epc;
    if (pc_set && pc_sel == PC_DRET) t = depc;
    if (pc_set && pc_sel == PC_EXCEPTION) begin
      case (exc_sel)
        EXC_ILLINSN:    t = page + 32'(OFF_ILLINSN);
        EXC_ECALL:      t = page + 32'(OFF_ECALL);
        EXC_BREAKPOINT: t = page + 32'(OFF_BREAKPOINT);
        EXC_IRQ:        t = page + 32'(irq_id) * 32'd4;
        EXC_DBD:        t = DM_HALT_ADDR;
        default:        t = DM_EXC_ADDR;
      endcase
    end
    return t & ~32'h3;
  endfunction

  task automatic wait_accepts(input int n);
    int goal;
    goal = accept_cnt + n;
    while (accept_cnt < goal) @(negedge clk);
  endtask

  task automatic do_redirect(input pc_sel_e sel, input exc_sel_e exc, input string name);
    @(negedge clk);
    pc_sel      = sel;
    exc_sel     = exc;
    irq_id      = irq_id_t'($urandom);
    jump_target = $urandom;
    epc         = $urandom;
    depc        = $urandom;
    phase_name  = name;
    pc_set      = 1'b1;
    @(negedge clk);
    pc_set = 1'b0;
    wait_accepts(6);
    repeat ($urandom_range(0, 5)) @(negedge clk);
  endtask

  ////////////////////////////////////////
  // reference model of the decode stream
  ////////////////////////////////////////
  assign accept = instr_valid & instr_ready;

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      {req_seen, first_q, hold_q, valid_hold_q, bus_wait_q} <= '0;
      {exp_pc, hold_pc, hold_instr, bus_addr_q} <= '0;
      accept_cnt <= 0;
      out_cnt    <= 0;
    end else begin
      // a redirect or the first request restarts the stream
      if (pc_set || (req && !req_seen)) begin
        exp_pc  <= redirect_target();
        first_q <= 1'b1;
      end else if (accept) begin
        exp_pc  <= exp_pc + 32'd4;
        first_q <= 1'b0;
      end
      req_seen     <= req_seen | req;
      accept_cnt   <= accept_cnt + (accept ? 1 : 0);
      // outstanding count from the bus events
      out_cnt      <= out_cnt + ((instr_req && instr_gnt) ? 1 : 0) - (instr_rvalid ? 1 : 0);
      hold_q       <= halt | (instr_valid & ~instr_ready);
      valid_hold_q <= instr_valid & ~instr_ready & ~pc_set;
      hold_pc      <= pc;
      hold_instr   <= instr;
      bus_wait_q   <= instr_req & ~instr_gnt;
      bus_addr_q   <= instr_addr;
    end
  end

  a_quiet: assert property (@(posedge clk) (!req && !req_seen) |-> (!instr_req && !instr_valid))
    else report_value("reset", 32'd0, $sampled({30'd0, instr_req, instr_valid}));
  a_data: assert property (@(posedge clk) disable iff (!rst_n) accept |-> (instr == ~pc))
    else report_value("data", ~$sampled(pc), $sampled(instr));
  a_target: assert property (@(posedge clk) disable iff (!rst_n)
    (accept && first_q) |-> (pc == exp_pc))
    else report_value(phase_name, $sampled(exp_pc), $sampled(pc));
  a_sequence: assert property (@(posedge clk) disable iff (!rst_n)
    (accept && !first_q) |-> (pc == exp_pc))
    else report_value("sequence", $sampled(exp_pc), $sampled(pc));
  a_hold_pc: assert property (@(posedge clk) disable iff (!rst_n) hold_q |-> (pc == hold_pc))
    else report_value("hold pc", $sampled(hold_pc), $sampled(pc));
  a_hold_instr: assert property (@(posedge clk) disable iff (!rst_n)
    hold_q |-> (instr == hold_instr))
    else report_value("hold instr", $sampled(hold_instr), $sampled(instr));
  a_valid_hold: assert property (@(posedge clk) disable iff (!rst_n) valid_hold_q |-> instr_valid)
    else report_value("stall valid", 32'd1, 32'($sampled(instr_valid)));
  a_outstanding: assert property (@(posedge clk) disable iff (!rst_n) out_cnt <= PF_DEPTH)
    else report_value("outstanding", PF_DEPTH, $sampled(out_cnt));
  a_req_hold: assert property (@(posedge clk) disable iff (!rst_n) bus_wait_q |-> instr_req)
    else report_msg("bus request withdrawn before grant");
  a_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bus_wait_q |-> (instr_addr == bus_addr_q))
    else report_value("bus address", $sampled(bus_addr_q), $sampled(instr_addr));

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // decode accepts at random, or stalls for a whole phase
  always @(negedge clk) begin
    instr_ready <= stall_mode ? 1'b0 : ($urandom_range(0, 3) != 0);
  end

  initial begin
    #(PHASES * CYCLES_PER_PHASE * 100);
    report_msg("watchdog expired, the run did not finish in time");
  end

  initial begin
    void'($urandom(32'hdfe1df38));
    rst_n       = 1'b0;
    boot_addr   = 32'h2000_0000;
    {req, pc_set, halt} = '0;
    pc_sel      = PC_JUMP;
    exc_sel     = EXC_ILLINSN;
    irq_id      = '0;
    {jump_target, epc, depc} = '0;
    phase_name  = "boot";
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    req = 1'b1;
    wait_accepts(24);
    do_redirect(PC_JUMP, EXC_ILLINSN, "jump");
    do_redirect(PC_ERET, EXC_ILLINSN, "eret");
    do_redirect(PC_DRET, EXC_ILLINSN, "dret");
    do_redirect(PC_EXCEPTION, EXC_ILLINSN, "illegal instruction");
    do_redirect(PC_EXCEPTION, EXC_ECALL, "ecall");
    do_redirect(PC_EXCEPTION, EXC_BREAKPOINT, "breakpoint");
    do_redirect(PC_EXCEPTION, EXC_IRQ, "irq vector");
    do_redirect(PC_EXCEPTION, EXC_DBD, "debug halt");
    do_redirect(PC_EXCEPTION, EXC_DBGEXC, "debug exception");
    do_redirect(PC_BOOT, EXC_ILLINSN, "boot redirect");
    // back-pressure fills the queue, then halt
    stall_mode <= 1'b1;
    repeat (12) @(negedge clk);
    stall_mode <= 1'b0;
    wait_accepts(8);
    halt = 1'b1;
    repeat ($urandom_range(6, 14)) @(negedge clk);
    halt = 1'b0;
    wait_accepts(8);
    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
verilog/fetch_pkg.sv
verilog/fetch_addr_sel.sv
verilog/prefetch_buffer.sv
verilog/if_id_reg.sv
verilog/fetch_top.sv
verification/tb_instr_mem.sv
verification/tb_fetch_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator and run it, the exit status carries the result
verilator --binary --assert -Wno-fatal --top-module tb_fetch_top -f sim.f -o tb_fetch_top \
  && ./obj_dir/tb_fetch_top \
  || exit 1
